// File: hw/rv_fwd_pkg.sv
package rv_fwd_pkg;

    ////////////////////////////////////////
    // register file geometry.
    ////////////////////////////////////////

    // one integer word.
    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    ////////////////////////////////////////
    // operand sources.
    ////////////////////////////////////////

    // newest producer of an operand.
    typedef enum logic [1:0] {
        src_rf  = 2'd0,
        src_ex  = 2'd1,
        src_mem = 2'd2,
        src_wb  = 2'd3
    } fwd_src_e;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_fwd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] rd_addr,
    input  logic [xlen-1:0]       rd_data,
    output logic [xlen-1:0]       rs1_rdata,
    output logic [xlen-1:0]       rs2_rdata
);

    logic [xlen-1:0] regs [reg_count];
    logic            wr_en;

    // x0 is never written.
    assign wr_en = we && (rd_addr != '0);

    ////////////////////////////////////////
    // write port.
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_addr] <= rd_data;
        end
    end

    ////////////////////////////////////////
    // read ports.
    ////////////////////////////////////////

    // x0 reads its cleared storage.
    assign rs1_rdata = regs[rs1_addr];
    assign rs2_rdata = regs[rs2_addr];

    ////////////////////////////////////////
    // checks.
    ////////////////////////////////////////

    // storage behind x0 survives any write sequence.
    x0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs[0] == '0
    ) else $error("reg_file: x0 storage changed");

endmodule

// File: hw/fwd_detect.sv
`timescale 1ns/1ps

module fwd_detect import rv_fwd_pkg::*; (
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  logic [reg_addr_w-1:0] ex_rd_addr,
    input  logic                  ex_rd_we,
    input  logic                  ex_is_load,
    input  logic [reg_addr_w-1:0] mem_rd_addr,
    input  logic                  mem_rd_we,
    input  logic [reg_addr_w-1:0] wb_rd_addr,
    input  logic                  wb_we,
    output fwd_src_e              rs1_src,
    output fwd_src_e              rs2_src,
    output logic                  load_stall
);

    ////////////////////////////////////////
    // match helpers.
    ////////////////////////////////////////

    // stage writes a real register that equals the source.
    function automatic logic stage_hit(
        input logic [reg_addr_w-1:0] rs,
        input logic [reg_addr_w-1:0] rd,
        input logic                  rd_we
    );
        return rd_we && (rd != '0) && (rd == rs);
    endfunction

    // newest stage wins.
    function automatic fwd_src_e pick_src(
        input logic [reg_addr_w-1:0] rs
    );
        fwd_src_e src;
        if (rs == '0) begin
            src = src_rf;
        end else if (stage_hit(rs, ex_rd_addr, ex_rd_we)) begin
            src = src_ex;
        end else if (stage_hit(rs, mem_rd_addr, mem_rd_we)) begin
            src = src_mem;
        end else if (stage_hit(rs, wb_rd_addr, wb_we)) begin
            src = src_wb;
        end else begin
            src = src_rf;
        end
        return src;
    endfunction

    ////////////////////////////////////////
    // sources and stall.
    ////////////////////////////////////////

    always_comb begin
        rs1_src = pick_src(rs1_addr);
        rs2_src = pick_src(rs2_addr);

        // load result not ready until after memory.
        load_stall = ex_is_load
                     && (stage_hit(rs1_addr, ex_rd_addr, ex_rd_we)
                         || stage_hit(rs2_addr, ex_rd_addr, ex_rd_we));

        // a stall always pairs with an execute forward.
        if (load_stall) begin
            stall_has_ex_fwd: assert (ex_is_load
                                      && ((rs1_src == src_ex) || (rs2_src == src_ex)))
                else $error("fwd_detect: load stall without execute forward");
        end
    end

endmodule

// File: hw/operand_sel.sv
`timescale 1ns/1ps

module operand_sel import rv_fwd_pkg::*; (
    input  fwd_src_e        rs1_src,
    input  fwd_src_e        rs2_src,
    input  logic [xlen-1:0] rf_rs1_data,
    input  logic [xlen-1:0] rf_rs2_data,
    input  logic [xlen-1:0] ex_result,
    input  logic [xlen-1:0] mem_result,
    input  logic [xlen-1:0] wb_result,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data
);

    ////////////////////////////////////////
    // four-way select.
    ////////////////////////////////////////

    // stage results are common to both operands.
    function automatic logic [xlen-1:0] pick_word(
        input fwd_src_e        src,
        input logic [xlen-1:0] rf_word
    );
        logic [xlen-1:0] word;
        case (src)
            src_ex:  word = ex_result;
            src_mem: word = mem_result;
            src_wb:  word = wb_result;
            default: word = rf_word;
        endcase
        return word;
    endfunction

    always_comb begin
        rs1_data = pick_word(rs1_src, rf_rs1_data);
        rs2_data = pick_word(rs2_src, rf_rs2_data);

        // detector must hand over a defined source.
        src_legal: assert ((rs1_src inside {src_rf, src_ex, src_mem, src_wb})
                           && (rs2_src inside {src_rf, src_ex, src_mem, src_wb}))
            else $error("operand_sel: illegal forward source");
    end

endmodule

// File: hw/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch import rv_fwd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  logic [reg_addr_w-1:0] ex_rd_addr,
    input  logic                  ex_rd_we,
    input  logic                  ex_is_load,
    input  logic [xlen-1:0]       ex_result,
    input  logic [reg_addr_w-1:0] mem_rd_addr,
    input  logic                  mem_rd_we,
    input  logic [xlen-1:0]       mem_result,
    input  logic [reg_addr_w-1:0] wb_rd_addr,
    input  logic                  wb_we,
    input  logic [xlen-1:0]       wb_result,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data,
    output logic                  load_stall
);

    logic [xlen-1:0] rf_rs1_data;
    logic [xlen-1:0] rf_rs2_data;
    fwd_src_e        rs1_src;
    fwd_src_e        rs2_src;

    ////////////////////////////////////////
    // register read and hazard detect.
    ////////////////////////////////////////

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .we        (wb_we),
        .rd_addr   (wb_rd_addr),
        .rd_data   (wb_result),
        .rs1_rdata (rf_rs1_data),
        .rs2_rdata (rf_rs2_data)
    );

    fwd_detect u_fwd_detect (
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .ex_rd_addr  (ex_rd_addr),
        .ex_rd_we    (ex_rd_we),
        .ex_is_load  (ex_is_load),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_we   (mem_rd_we),
        .wb_rd_addr  (wb_rd_addr),
        .wb_we       (wb_we),
        .rs1_src     (rs1_src),
        .rs2_src     (rs2_src),
        .load_stall  (load_stall)
    );

    ////////////////////////////////////////
    // operand select.
    ////////////////////////////////////////

    operand_sel u_operand_sel (
        .rs1_src     (rs1_src),
        .rs2_src     (rs2_src),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .ex_result   (ex_result),
        .mem_result  (mem_result),
        .wb_result   (wb_result),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

endmodule

// File: sim/tb_operand_fetch.sv
`timescale 1ns/1ps

module tb_operand_fetch import rv_fwd_pkg::*; ();

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] ex_rd_addr;
    logic                  ex_rd_we;
    logic                  ex_is_load;
    logic [xlen-1:0]       ex_result;
    logic [reg_addr_w-1:0] mem_rd_addr;
    logic                  mem_rd_we;
    logic [xlen-1:0]       mem_result;
    logic [reg_addr_w-1:0] wb_rd_addr;
    logic                  wb_we;
    logic [xlen-1:0]       wb_result;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  load_stall;

    logic [xlen-1:0] shadow [reg_count];
    logic [xlen-1:0] exp_rs1;
    logic [xlen-1:0] exp_rs2;
    logic            exp_stall;
    logic [15:0]     lfsr_state = 16'd63;
    string           test_name = "reset";
    int              ex_hits = 0;
    int              mem_hits = 0;
    int              wb_hits = 0;
    int              stall_hits = 0;

    always #4 clk = ~clk;

    operand_fetch dut (.*);

    ////////////////////////////////////////
    // random source.
    ////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [63:0] v;
        v = take_bits(1);
        return v[0];
    endfunction

    // registers 0 to 7 only, so stages collide often.
    function automatic logic [reg_addr_w-1:0] rand_reg();
        logic [63:0] v;
        v = take_bits(3);
        return {2'b00, v[2:0]};
    endfunction

    function automatic logic [reg_addr_w-1:0] nonzero_reg();
        logic [reg_addr_w-1:0] r;
        r = rand_reg();
        if (r == '0) begin
            r = 5'd7;
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // reference model.
    ////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_we && (wb_rd_addr != '0)) begin
            shadow[wb_rd_addr] <= wb_result;
        end
    end

    // newest writer of a nonzero register wins.
    function automatic fwd_src_e classify(input logic [reg_addr_w-1:0] rs);
        fwd_src_e src;
        if (rs == '0) begin
            src = src_rf;
        end else if (ex_rd_we && (ex_rd_addr == rs)) begin
            src = src_ex;
        end else if (mem_rd_we && (mem_rd_addr == rs)) begin
            src = src_mem;
        end else if (wb_we && (wb_rd_addr == rs)) begin
            src = src_wb;
        end else begin
            src = src_rf;
        end
        return src;
    endfunction

    function automatic logic [xlen-1:0] expect_operand(input logic [reg_addr_w-1:0] rs);
        logic [xlen-1:0] v;
        case (classify(rs))
            src_ex:  v = ex_result;
            src_mem: v = mem_result;
            src_wb:  v = wb_result;
            default: v = shadow[rs];
        endcase
        return v;
    endfunction

    always_comb begin
        exp_rs1   = expect_operand(rs1_addr);
        exp_rs2   = expect_operand(rs2_addr);
        exp_stall = ex_rd_we && ex_is_load && (ex_rd_addr != '0)
                    && ((ex_rd_addr == rs1_addr) || (ex_rd_addr == rs2_addr));
    end

    ////////////////////////////////////////
    // checks.
    ////////////////////////////////////////

    task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("FAIL %s %s expected %h actual %h", test_name, what, exp_v, act_v);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout in %s: %s", test_name, what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    rs1_matches: assert property (@(negedge clk) disable iff (!rst_n) rs1_data == exp_rs1)
        else report_mismatch("rs1_data", exp_rs1, rs1_data);

    rs2_matches: assert property (@(negedge clk) disable iff (!rst_n) rs2_data == exp_rs2)
        else report_mismatch("rs2_data", exp_rs2, rs2_data);

    stall_matches: assert property (@(negedge clk) disable iff (!rst_n) load_stall == exp_stall)
        else report_mismatch("load_stall", {63'd0, exp_stall}, {63'd0, load_stall});

    // forward paths reached by the random mix.
    always @(negedge clk) begin
        if (rst_n && (test_name == "random_mix")) begin
            if ((classify(rs1_addr) == src_ex) || (classify(rs2_addr) == src_ex)) begin
                ex_hits <= ex_hits + 1;
            end
            if ((classify(rs1_addr) == src_mem) || (classify(rs2_addr) == src_mem)) begin
                mem_hits <= mem_hits + 1;
            end
            if ((classify(rs1_addr) == src_wb) || (classify(rs2_addr) == src_wb)) begin
                wb_hits <= wb_hits + 1;
            end
            if (exp_stall) begin
                stall_hits <= stall_hits + 1;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus.
    ////////////////////////////////////////

    task automatic drive_cycle(
        input logic [reg_addr_w-1:0] rs1, input logic [reg_addr_w-1:0] rs2,
        input logic [reg_addr_w-1:0] ex_rd, input logic ex_w, input logic ex_ld,
        input logic [reg_addr_w-1:0] mem_rd, input logic mem_w,
        input logic [reg_addr_w-1:0] wb_rd, input logic wb_w
    );
        @(posedge clk);
        rs1_addr    <= rs1;
        rs2_addr    <= rs2;
        ex_rd_addr  <= ex_rd;
        ex_rd_we    <= ex_w;
        ex_is_load  <= ex_ld;
        ex_result   <= take_bits(64);
        mem_rd_addr <= mem_rd;
        mem_rd_we   <= mem_w;
        mem_result  <= take_bits(64);
        wb_rd_addr  <= wb_rd;
        wb_we       <= wb_w;
        wb_result   <= take_bits(64);
    endtask

    initial begin
        int                    cycles;
        logic [reg_addr_w-1:0] r;

        rst_n       <= 1'b0;
        rs1_addr    <= '0;
        rs2_addr    <= '0;
        ex_rd_addr  <= '0;
        ex_rd_we    <= 1'b0;
        ex_is_load  <= 1'b0;
        ex_result   <= '0;
        mem_rd_addr <= '0;
        mem_rd_we   <= 1'b0;
        mem_result  <= '0;
        wb_rd_addr  <= '0;
        wb_we       <= 1'b0;
        wb_result   <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "reset_idle";
        for (int i = 0; i < 16; i++) begin
            drive_cycle(i[4:0], 5'(31 - i), '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        end

        // write every register, then read it all back idle.
        test_name = "rf_write_back";
        for (int i = 1; i < reg_count; i++) begin
            drive_cycle(i[4:0], 5'(i - 1), '0, 1'b0, 1'b0, '0, 1'b0, i[4:0], 1'b1);
        end
        drive_cycle('0, 5'd1, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b1);
        for (int i = 0; i < 16; i++) begin
            drive_cycle(i[4:0], 5'(i + 16), '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        end

        test_name = "ex_over_mem";
        repeat (8) begin
            r = nonzero_reg();
            drive_cycle(r, rand_reg(), r, 1'b1, 1'b0, r, 1'b1, r, 1'b1);
        end

        test_name = "mem_fwd";
        repeat (8) begin
            r = nonzero_reg();
            drive_cycle(r, r, r + 5'd8, 1'b1, 1'b0, r, 1'b1, r, 1'b1);
        end

        test_name = "wb_fwd";
        repeat (8) begin
            r = nonzero_reg();
            drive_cycle(r, r + 5'd16, r + 5'd8, 1'b1, 1'b0, r + 5'd16, 1'b1, r, 1'b1);
        end

        test_name = "load_stall";
        repeat (4) begin
            r = nonzero_reg();
            drive_cycle(r + 5'd8, r, r, 1'b1, 1'b1, '0, 1'b0, '0, 1'b0);
            drive_cycle(r, r + 5'd8, r, 1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
            drive_cycle('0, '0, '0, 1'b1, 1'b1, '0, 1'b0, '0, 1'b0);
            drive_cycle(r, r, r, 1'b0, 1'b1, '0, 1'b0, '0, 1'b0);
            drive_cycle(r, r, r + 5'd8, 1'b1, 1'b1, r, 1'b1, '0, 1'b0);
        end

        test_name = "x0_zero";
        repeat (4) begin
            drive_cycle('0, '0, '0, 1'b1, 1'b1, '0, 1'b1, '0, 1'b1);
        end

        // random mix until every path and the stall were seen.
        test_name = "random_mix";
        cycles = 0;
        while ((cycles < 300) || (ex_hits == 0) || (mem_hits == 0)
               || (wb_hits == 0) || (stall_hits == 0)) begin
            if (cycles >= 3000) begin
                fail_timeout("random stimulus never reached every forward path");
            end
            drive_cycle(rand_reg(), rand_reg(), rand_reg(), rand_bit(), rand_bit(),
                        rand_reg(), rand_bit(), rand_reg(), rand_bit());
            cycles++;
        end

        drive_cycle('0, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        @(negedge clk);
        @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: vlog.f
hw/rv_fwd_pkg.sv
hw/reg_file.sv
hw/fwd_detect.sv
hw/operand_sel.sv
hw/operand_fetch.sv
sim/tb_operand_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the operand fetch testbench with Verilator.
set -e

cd "$(dirname "$0")"

log=sim.log
fail_msg='*** FAILED ***'
pass_msg='*** PASSED ***'

verilator --binary --timing --assert \
    --top-module tb_operand_fetch \
    -Mdir obj_dir -o sim_tb \
    -f vlog.f

./obj_dir/sim_tb > "$log" 2>&1 || true
cat "$log"

if grep -qF "$fail_msg" "$log"; then
    echo "simulation reported a failure"
    exit 1
elif ! grep -qF "$pass_msg" "$log"; then
    echo "simulation ended without reporting a result"
    exit 1
fi
